// ==== source/phy_geometry_pkg.sv ====
/* Geometry of one half-rate interface with two read DQS groups.
   Every width below follows from the group count, the group width and the rate. */
package phy_geometry_pkg;

	// Read DQS groups on the interface
	localparam int NUM_DQS_GROUPS = 2;

	// DQ pins served by one DQS group
	localparam int DQ_PER_GROUP = 4;

	// All DQ pins of the interface
	localparam int MEM_DQ_WIDTH = NUM_DQS_GROUPS * DQ_PER_GROUP;

	// Half rate gives two memory clocks per AFI clock
	localparam int AFI_RATE_RATIO = 2;

	// Each memory clock carries two beats, so an AFI word holds four time slots
	localparam int SLOTS_PER_AFI = 2 * AFI_RATE_RATIO;

	// One DDIO capture of a group
	// Index 1 is the later time slot and index 0 the earlier one
	typedef logic [1:0][DQ_PER_GROUP-1:0] ddio_word_t;

	// Four time slots of one group, slot 3 in the top nibble
	typedef logic [SLOTS_PER_AFI-1:0][DQ_PER_GROUP-1:0] group_afi_word_t;

	// Full AFI read word across all groups and time slots
	typedef logic [SLOTS_PER_AFI*MEM_DQ_WIDTH-1:0] afi_rdata_t;

endpackage

// ==== source/read_ctrl_pkg.sv ====
/* Read control types shared between the latency tracker and the output mapper.
   The latency setting counts AFI clock cycles. */
package read_ctrl_pkg;

	// Width of the read latency setting from the sequencer
	localparam int LAT_COUNT_WIDTH = 5;

	// Read latency in AFI cycles
	typedef logic [LAT_COUNT_WIDTH-1:0] lat_count_t;

	// ********************************************************************
	// Delayed read request
	// ********************************************************************

	// Read enable pops the data FIFOs
	// Read valid qualifies the word the FIFOs present one cycle later
	// Both come from the same tap, so they are high in the same cycle
	typedef struct packed {
		logic read_enable;
		logic read_valid;
	} rd_ctrl_t;

endpackage

// ==== source/read_latency_tracker.sv ====
/* Latency settings from 0 to MAX_READ_LATENCY-1 work; a larger setting never fires.
   MAX_READ_LATENCY must be at least 2. */
`timescale 1ns/1ps

module read_latency_tracker #(
	parameter int MAX_READ_LATENCY = 24
) (
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  logic                      afi_rdata_en_i,
	input  read_ctrl_pkg::lat_count_t latency_i,
	output read_ctrl_pkg::rd_ctrl_t   rd_ctrl_o
);

	// Stage n holds the request sampled n+1 edges ago
	logic [MAX_READ_LATENCY-1:0] req_shift_q;

	// Stage picked by the latency setting
	logic tap;

	read_ctrl_pkg::rd_ctrl_t rd_ctrl_q;

	// ********************************************************************
	// Request shift register
	// ********************************************************************

	// Every AFI cycle the controller's read request moves one stage on
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			req_shift_q <= '0;
		else
			req_shift_q <= {req_shift_q[MAX_READ_LATENCY-2:0], afi_rdata_en_i};
	end

	// Pick stage L of the shifter
	// Settings past the last stage read as no request
	always_comb
	begin
		tap = 1'b0;
		if (int'(latency_i) < MAX_READ_LATENCY)
			tap = req_shift_q[latency_i];
	end

	// One register after the tap, so a request at edge E shows up after E+L+1
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			rd_ctrl_q <= '0;
		else
		begin
			rd_ctrl_q.read_enable <= tap;
			rd_ctrl_q.read_valid  <= tap;
		end
	end

	assign rd_ctrl_o = rd_ctrl_q;

endmodule

// ==== source/read_data_fifo.sv ====
/* FIFO_DEPTH must be a power of two and at least 2. There is no full or empty flag,
   so the controller must never request more words than were captured. */
`timescale 1ns/1ps

module read_data_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                              pll_afi_clk,
	input  logic                              reset_n_afi_clk,
	input  logic                              read_capture_clk_i,
	input  logic                              fifo_reset_i,
	input  phy_geometry_pkg::ddio_word_t      ddio_dq_i,
	input  logic                              read_enable_i,
	output phy_geometry_pkg::group_afi_word_t rdata_o
);

	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	// Low halves hold time slots 1 and 0, high halves hold slots 3 and 2
	phy_geometry_pkg::ddio_word_t mem_lo [FIFO_DEPTH];
	phy_geometry_pkg::ddio_word_t mem_hi [FIFO_DEPTH];

	logic [PTR_WIDTH-1:0] wr_ptr_q;
	logic [PTR_WIDTH-1:0] rd_ptr_q;

	// Low while the next capture goes into the low half
	logic wr_half_q;

	// Active-low FIFO reset, registered on the AFI clock
	logic fifo_rst_n_q;

	phy_geometry_pkg::group_afi_word_t rdata_q;

	// Sequencer reset request, or system reset, pulls the pointers back to zero
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			fifo_rst_n_q <= 1'b0;
		else
			fifo_rst_n_q <= ~fifo_reset_i;
	end

	// ********************************************************************
	// Write side on the capture clock
	// ********************************************************************

	// The AFI-domain reset is asynchronous to the capture clock
	// The sequencer only releases it while no read data arrives, so the
	// pointer and half flag are stable at zero when it lets go
	always_ff @(posedge read_capture_clk_i or negedge fifo_rst_n_q)
	begin
		if (!fifo_rst_n_q)
		begin
			wr_half_q <= 1'b0;
			wr_ptr_q  <= '0;
		end
		else
		begin
			wr_half_q <= ~wr_half_q;
			// A word is complete once its high half has landed
			if (wr_half_q)
				wr_ptr_q <= wr_ptr_q + 1'b1;
		end
	end

	// Captures alternate between the two halves of the same entry
	always_ff @(posedge read_capture_clk_i)
	begin
		if (wr_half_q)
			mem_hi[wr_ptr_q] <= ddio_dq_i;
		else
			mem_lo[wr_ptr_q] <= ddio_dq_i;
	end

	// ********************************************************************
	// Read side on the AFI clock
	// ********************************************************************

	// The FIFO reset clears the read pointer on an AFI edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			rd_ptr_q <= '0;
		else if (!fifo_rst_n_q)
			rd_ptr_q <= '0;
		else if (read_enable_i)
			rd_ptr_q <= rd_ptr_q + 1'b1;
	end

	// The whole word is registered at the edge where read enable is high
	// and holds until the next read
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			rdata_q <= '0;
		else if (read_enable_i)
			rdata_q <= {mem_hi[rd_ptr_q], mem_lo[rd_ptr_q]};
	end

	assign rdata_o = rdata_q;

endmodule

// ==== source/read_output_mapper.sv ====
/* Read valid is registered at the same edge as the FIFO output words,
   so valid and data leave this block aligned. */
`timescale 1ns/1ps

module read_output_mapper (
	input  logic                              pll_afi_clk,
	input  logic                              reset_n_afi_clk,
	input  read_ctrl_pkg::rd_ctrl_t           rd_ctrl_i,
	input  phy_geometry_pkg::group_afi_word_t group_data_i [phy_geometry_pkg::NUM_DQS_GROUPS],
	output phy_geometry_pkg::afi_rdata_t      afi_rdata_o,
	output phy_geometry_pkg::afi_rdata_t      phy_mux_read_fifo_q_o,
	output logic                              afi_rdata_valid_o
);

	localparam int GROUP_WORD_WIDTH = $bits(phy_geometry_pkg::group_afi_word_t);

	logic rdata_valid_q;

	// Valid lines up with the word that the FIFOs register on this same edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			rdata_valid_q <= 1'b0;
		else
			rdata_valid_q <= rd_ctrl_i.read_valid;
	end

	assign afi_rdata_valid_o = rdata_valid_q;

	// ********************************************************************
	// Data orderings
	// ********************************************************************

	// Controller view is ordered by time slot, then by group
	// For two groups that gives G1_T3, G0_T3, ... G1_T0, G0_T0
	always_comb
	begin
		for (int g = 0; g < phy_geometry_pkg::NUM_DQS_GROUPS; g++)
		begin
			for (int t = 0; t < phy_geometry_pkg::SLOTS_PER_AFI; t++)
			begin
				afi_rdata_o[phy_geometry_pkg::MEM_DQ_WIDTH*t + phy_geometry_pkg::DQ_PER_GROUP*g
					+: phy_geometry_pkg::DQ_PER_GROUP] = group_data_i[g][t];
			end
		end
	end

	// Sequencer view keeps each group's word whole, group 1 on top
	// This lets calibration look at one group without unpicking slots
	always_comb
	begin
		for (int g = 0; g < phy_geometry_pkg::NUM_DQS_GROUPS; g++)
		begin
			phy_mux_read_fifo_q_o[GROUP_WORD_WIDTH*g +: GROUP_WORD_WIDTH] = group_data_i[g];
		end
	end

endmodule

// ==== source/read_datapath_top.sv ====
/* Read data returns exactly L+2 AFI cycles after the request, L being the sequencer's
   latency setting. Each capture clock must run at twice the AFI clock frequency. */
`timescale 1ns/1ps

module read_datapath_top #(
	parameter int MAX_READ_LATENCY = 24,
	parameter int FIFO_DEPTH       = 8
) (
	input  logic                                          pll_afi_clk,
	input  logic                                          reset_n_afi_clk,
	input  logic                                          afi_rdata_en_i,
	input  read_ctrl_pkg::lat_count_t                     seq_read_latency_counter_i,
	input  logic [phy_geometry_pkg::NUM_DQS_GROUPS-1:0]   seq_read_fifo_reset_i,
	input  logic [phy_geometry_pkg::NUM_DQS_GROUPS-1:0]   read_capture_clk_i,
	input  logic [phy_geometry_pkg::NUM_DQS_GROUPS*
		$bits(phy_geometry_pkg::ddio_word_t)-1:0]           ddio_phy_dq_i,
	output phy_geometry_pkg::afi_rdata_t                  afi_rdata_o,
	output phy_geometry_pkg::afi_rdata_t                  phy_mux_read_fifo_q_o,
	output logic                                          afi_rdata_valid_o
);

	// Bits of one group's DDIO capture on the ddio_phy_dq_i bus
	localparam int DDIO_WIDTH = $bits(phy_geometry_pkg::ddio_word_t);

	// Delayed read request, shared by every group
	read_ctrl_pkg::rd_ctrl_t rd_ctrl;

	// Registered FIFO output of each group
	phy_geometry_pkg::group_afi_word_t group_data [phy_geometry_pkg::NUM_DQS_GROUPS];

	// ********************************************************************
	// Latency tracking
	// ********************************************************************

	// All groups are calibrated to one latency, so a single tracker serves them
	read_latency_tracker #(
		.MAX_READ_LATENCY (MAX_READ_LATENCY)
	) tracker_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.latency_i       (seq_read_latency_counter_i),
		.rd_ctrl_o       (rd_ctrl)
	);

	// One resynchronisation FIFO per DQS group
	// Group g takes its DDIO slice from bits DDIO_WIDTH*g upward
	for (genvar g = 0; g < phy_geometry_pkg::NUM_DQS_GROUPS; g++)
	begin : gen_group_fifo
		read_data_fifo #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) fifo_i (
			.pll_afi_clk        (pll_afi_clk),
			.reset_n_afi_clk    (reset_n_afi_clk),
			.read_capture_clk_i (read_capture_clk_i[g]),
			.fifo_reset_i       (seq_read_fifo_reset_i[g]),
			.ddio_dq_i          (ddio_phy_dq_i[DDIO_WIDTH*g +: DDIO_WIDTH]),
			.read_enable_i      (rd_ctrl.read_enable),
			.rdata_o            (group_data[g])
		);
	end

	// ********************************************************************
	// Output ordering
	// ********************************************************************

	read_output_mapper mapper_i (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.rd_ctrl_i             (rd_ctrl),
		.group_data_i          (group_data),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o)
	);

endmodule

// ==== verification/read_datapath_tb.sv ====
/* Capture clocks are gated so that each group captures only the words a test asks for.
   Every test writes as many words as it reads, which keeps the FIFOs in step with the model. */
`timescale 1ns/1ps

module read_datapath_tb;

	localparam int MAX_READ_LATENCY = 24;
	localparam int FIFO_DEPTH = 8;
	localparam int AFI_PERIOD_NS = 20;
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES = 10;
	localparam int FIFO_RESET_CYCLES = 3;
	localparam int NUM_BURSTS = 6;

	// Each burst flushes the tracker, fills the FIFOs and waits out its own latency
	localparam int BURST_CYCLES = 2 * MAX_READ_LATENCY + 2 * FIFO_DEPTH + 9;
	localparam int TEST_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_BURSTS * BURST_CYCLES
		+ FIFO_DEPTH + FIFO_RESET_CYCLES + 3;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	logic afi_rdata_en_i;
	read_ctrl_pkg::lat_count_t seq_read_latency_counter_i;
	logic [phy_geometry_pkg::NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i;
	logic [phy_geometry_pkg::NUM_DQS_GROUPS-1:0] read_capture_clk_i;
	logic [15:0] ddio_phy_dq_i;
	phy_geometry_pkg::afi_rdata_t afi_rdata_o;
	phy_geometry_pkg::afi_rdata_t phy_mux_read_fifo_q_o;
	logic afi_rdata_valid_o;

	// Free-running capture clocks and their gates, one pair per group
	logic cap_raw_g0;
	logic cap_raw_g1;
	logic cap_en_g0;
	logic cap_en_g1;
	phy_geometry_pkg::ddio_word_t ddio_g0;
	phy_geometry_pkg::ddio_word_t ddio_g1;

	// DDIO captures still to be written, counted in halves
	int halves_g0;
	int halves_g1;

	// Model of each group's FIFO, every captured DDIO word in order
	phy_geometry_pkg::ddio_word_t model_g0 [$];
	phy_geometry_pkg::ddio_word_t model_g1 [$];

	logic [31:0] lcg_state;

	assign read_capture_clk_i = {cap_raw_g1 & cap_en_g1, cap_raw_g0 & cap_en_g0};
	assign ddio_phy_dq_i = {ddio_g1, ddio_g0};

	read_datapath_top #(
		.MAX_READ_LATENCY (MAX_READ_LATENCY),
		.FIFO_DEPTH       (FIFO_DEPTH)
	) dut_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.read_capture_clk_i         (read_capture_clk_i),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.afi_rdata_o                (afi_rdata_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o)
	);

	// ********************************************************************
	// Clocks and capture drivers
	// ********************************************************************

	always #(AFI_PERIOD_NS / 2) pll_afi_clk = ~pll_afi_clk;

	// Capture clocks run at twice the AFI rate, each with its own phase
	initial
	begin
		cap_raw_g0 = 1'b0;
		#3;
		forever #5 cap_raw_g0 = ~cap_raw_g0;
	end

	initial
	begin
		cap_raw_g1 = 1'b0;
		#6;
		forever #5 cap_raw_g1 = ~cap_raw_g1;
	end

	// Data and gate change on the falling capture edge, so the gated clock never glitches
	always @(negedge cap_raw_g0)
	begin
		if (halves_g0 > 0)
		begin
			ddio_g0 = next_ddio_word();
			model_g0.push_back(ddio_g0);
			halves_g0 = halves_g0 - 1;
			cap_en_g0 = 1'b1;
		end
		else
			cap_en_g0 = 1'b0;
	end

	always @(negedge cap_raw_g1)
	begin
		if (halves_g1 > 0)
		begin
			ddio_g1 = next_ddio_word();
			model_g1.push_back(ddio_g1);
			halves_g1 = halves_g1 - 1;
			cap_en_g1 = 1'b1;
		end
		else
			cap_en_g1 = 1'b0;
	end

	// ********************************************************************
	// Model helpers and compare tasks
	// ********************************************************************

	function automatic phy_geometry_pkg::ddio_word_t next_ddio_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// Slot t of group g goes to bit 8t + 4g of the controller word
	function automatic phy_geometry_pkg::afi_rdata_t slot_major(
		input phy_geometry_pkg::group_afi_word_t g0,
		input phy_geometry_pkg::group_afi_word_t g1);
		phy_geometry_pkg::afi_rdata_t word;
		for (int t = 0; t < phy_geometry_pkg::SLOTS_PER_AFI; t++)
		begin
			word[8*t +: 4] = g0[t];
			word[8*t+4 +: 4] = g1[t];
		end
		return word;
	endfunction

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	// The earlier capture holds slots 1 and 0, the later one slots 3 and 2
	task automatic pop_group_word(input int g, output phy_geometry_pkg::group_afi_word_t word);
		phy_geometry_pkg::ddio_word_t first;
		phy_geometry_pkg::ddio_word_t second;
		if ((g == 0 && model_g0.size() < 2) || (g == 1 && model_g1.size() < 2))
			stop_on_failure(
				$sformatf("A read returned data for group %0d but no word was written", g));
		else if (g == 0)
		begin
			first = model_g0.pop_front();
			second = model_g0.pop_front();
			word = {second, first};
		end
		else
		begin
			first = model_g1.pop_front();
			second = model_g1.pop_front();
			word = {second, first};
		end
	endtask

	task automatic check_rdata(input phy_geometry_pkg::afi_rdata_t expected,
		input phy_geometry_pkg::afi_rdata_t actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error at %0t ns: afi_rdata_o expected %h got %h",
				$time, expected, actual));
	endtask

	task automatic check_group_view(input phy_geometry_pkg::afi_rdata_t expected,
		input phy_geometry_pkg::afi_rdata_t actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error at %0t ns: phy_mux_read_fifo_q_o expected %h got %h",
				$time, expected, actual));
	endtask

	task automatic check_valid(input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error at %0t ns: afi_rdata_valid_o expected %b got %b",
				$time, expected, actual));
	endtask

	// Captures n whole words into both groups and waits until the last one has landed
	task automatic fill_words(input int n);
		@(negedge pll_afi_clk);
		halves_g0 = 2 * n;
		halves_g1 = 2 * n;
		wait (halves_g0 == 0 && halves_g1 == 0);
		repeat (2) @(negedge pll_afi_clk);
	endtask

	// Issues n back-to-back requests at latency lat and checks every cycle of the return
	// Sample i is taken after edge E+i, where E samples the first request
	task automatic read_burst(input int n, input int lat);
		int total;
		logic expect_valid;
		phy_geometry_pkg::group_afi_word_t g0;
		phy_geometry_pkg::group_afi_word_t g1;
		total = lat + n + 4;
		// Old requests must leave the shifter before the tap moves
		repeat (MAX_READ_LATENCY + 1) @(negedge pll_afi_clk);
		seq_read_latency_counter_i = read_ctrl_pkg::lat_count_t'(lat);
		@(negedge pll_afi_clk);
		afi_rdata_en_i = 1'b1;
		for (int i = 0; i < total; i++)
		begin
			@(negedge pll_afi_clk);
			if (i == n - 1)
				afi_rdata_en_i = 1'b0;
			expect_valid = (i >= lat + 2) && (i < lat + 2 + n);
			check_valid(expect_valid, afi_rdata_valid_o);
			if (expect_valid)
			begin
				pop_group_word(0, g0);
				pop_group_word(1, g1);
				check_rdata(slot_major(g0, g1), afi_rdata_o);
				check_group_view({g1, g0}, phy_mux_read_fifo_q_o);
			end
		end
	endtask

	// ********************************************************************
	// Directed tests
	// ********************************************************************

	task automatic test_idle_after_reset();
		for (int i = 0; i < IDLE_CYCLES; i++)
		begin
			@(negedge pll_afi_clk);
			check_valid(1'b0, afi_rdata_valid_o);
			check_rdata('0, afi_rdata_o);
		end
	endtask

	task automatic test_latency_sweep();
		int lat_list [3] = '{0, 5, 20};
		foreach (lat_list[i])
		begin
			fill_words(1);
			read_burst(1, lat_list[i]);
		end
	endtask

	task automatic test_burst_order();
		fill_words(4);
		read_burst(4, 5);
	endtask

	task automatic test_group_view();
		fill_words(3);
		read_burst(3, 20);
	endtask

	// Stale words written before the FIFO reset must never come back
	task automatic test_fifo_reset();
		fill_words(3);
		@(negedge pll_afi_clk);
		seq_read_fifo_reset_i = '1;
		repeat (FIFO_RESET_CYCLES) @(negedge pll_afi_clk);
		model_g0.delete();
		model_g1.delete();
		seq_read_fifo_reset_i = '0;
		repeat (2) @(negedge pll_afi_clk);
		fill_words(4);
		read_burst(4, 0);
	endtask

	initial
	begin
		#(TEST_CYCLES * AFI_PERIOD_NS * 2);
		stop_on_failure("Timeout: the tests did not finish in the time allowed");
	end

	initial
	begin
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		afi_rdata_en_i = 1'b0;
		seq_read_latency_counter_i = '0;
		seq_read_fifo_reset_i = '0;
		cap_en_g0 = 1'b0;
		cap_en_g1 = 1'b0;
		ddio_g0 = '0;
		ddio_g1 = '0;
		halves_g0 = 0;
		halves_g1 = 0;
		lcg_state = 32'hc652384e;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		reset_n_afi_clk = 1'b1;
		test_idle_after_reset();
		test_latency_sweep();
		test_burst_order();
		test_group_view();
		test_fifo_reset();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== filelist.f ====
source/phy_geometry_pkg.sv
source/read_ctrl_pkg.sv
source/read_latency_tracker.sv
source/read_data_fifo.sv
source/read_output_mapper.sv
source/read_datapath_top.sv
verification/read_datapath_tb.sv
